/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_vid -f tb.f -o vsim
sim_out=$(./obj_dir/vsim)
echo "$sim_out"

if echo "$sim_out" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1

/* source/vid_colmix.sv */
// Colour mixer with a 32-entry RGB555 palette
// Layer 0 uses palette entries 16..31 and sits in front of layer 1,
// which uses entries 0..15
// Blanking flags are delayed two pixel ticks to match the layer pixels
// Output is forced black outside the visible area
`timescale 1ns/1ns

module vid_colmix (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             pxl_cen,
    input  vid_pkg::vid_wr_t wr,
    input  logic [3:0]       pxl0,
    input  logic [3:0]       pxl1,
    input  logic             lhbl,
    input  logic             lvbl,
    output logic [4:0]       red,
    output logic [4:0]       green,
    output logic [4:0]       blue,
    output logic             lhbl_dly,
    output logic             lvbl_dly
);
    import vid_pkg::*;

    logic [14:0] pal_ram [PAL_WORDS];
    logic [4:0]  pal_idx;
    logic        lhbl_d1;
    logic        lvbl_d1;
    logic [14:0] rgb_q;

    always_ff @(posedge clk) begin
        if (wr.tgt == TGT_PAL) begin
            pal_ram[wr.idx[4:0]] <= wr.data[14:0];
        end
    end

    // Front layer wins unless transparent
    assign pal_idx = (pxl0 != 4'd0) ? {1'b1, pxl0} : {1'b0, pxl1};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lhbl_d1  <= 1'b0;
            lvbl_d1  <= 1'b0;
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
            rgb_q    <= '0;
        end else if (pxl_cen) begin
            lhbl_d1  <= lhbl;
            lvbl_d1  <= lvbl;
            lhbl_dly <= lhbl_d1;
            lvbl_dly <= lvbl_d1;
            rgb_q    <= (lhbl_d1 && lvbl_d1) ? pal_ram[pal_idx] : 15'd0;
        end
    end

    assign red   = rgb_q[14:10];
    assign green = rgb_q[9:5];
    assign blue  = rgb_q[4:0];

endmodule

/* source/vid_layer.sv */
// One scrolling tile layer over a 64x64 pixel plane of 8x8 tiles
// The plane wraps in both directions
// Graphics ROM must return data one clk after the address is presented
// Fetch runs in the three clk after each pxl_cen, so pxl_cen must be
// at most one clk in four
// A nibble value of 0 means transparent
`timescale 1ns/1ns

module vid_layer #(
    parameter vid_pkg::vid_target_e MAP_TGT = vid_pkg::TGT_MAP0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 pxl_cen,
    input  vid_pkg::vid_pos_t    pos,
    input  vid_pkg::vid_scroll_t scroll,
    input  vid_pkg::vid_wr_t     wr,
    output logic [10:0]          gfx_addr,
    input  logic [31:0]          gfx_data,
    output logic [3:0]           pxl
);
    import vid_pkg::*;

    logic [7:0]  map_ram [MAP_WORDS];
    logic [5:0]  plane_x;
    logic [5:0]  plane_y;
    logic [7:0]  tile_code;
    logic [2:0]  tile_row;
    logic [2:0]  tile_col;
    logic [31:0] row_data;
    logic [2:0]  fetch_st;

    // Scrolled plane coordinates, 6-bit sums wrap at 64
    assign plane_x = pos.h[5:0] + scroll.hscr;
    assign plane_y = pos.v + scroll.vscr;

    // Map entry index is tile row * 8 + tile column
    always_ff @(posedge clk) begin
        if (wr.tgt == MAP_TGT) begin
            map_ram[wr.idx] <= wr.data[7:0];
        end
    end

    // Fetch phases, one bit per clk after pxl_cen
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_st <= '0;
        end else begin
            fetch_st <= {fetch_st[1:0], pxl_cen};
        end
    end

    always_ff @(posedge clk) begin
        // Map read
        if (fetch_st[0]) begin
            tile_code <= map_ram[{plane_y[5:3], plane_x[5:3]}];
            tile_row  <= plane_y[2:0];
            tile_col  <= plane_x[2:0];
        end
        // ROM data has settled by now
        if (fetch_st[2]) begin
            row_data <= gfx_data;
        end
    end

    assign gfx_addr = {tile_code, tile_row};

    // Column c lives in nibble c
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            pxl <= row_data[{tile_col, 2'b00} +: 4];
        end
    end

endmodule

/* source/vid_mmr.sv */
// Write decoder for the video address map
// One write per cpu_we strobe, no back-pressure and no read-back
// Writes outside every region are dropped (tgt stays TGT_NONE)
// Only the low 6 bits of each scroll word are kept
`timescale 1ns/1ns

module vid_mmr (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cpu_we,
    input  logic [7:0]           cpu_addr,
    input  logic [15:0]          cpu_dout,
    output vid_pkg::vid_wr_t     wr,
    output vid_pkg::vid_scroll_t scroll0,
    output vid_pkg::vid_scroll_t scroll1
);
    import vid_pkg::*;

    vid_target_e dec_tgt;
    logic [5:0]  dec_idx;
    vid_target_e wr_tgt;
    logic [5:0]  wr_idx;
    logic [15:0] wr_data;

    function automatic logic in_region(input logic [7:0] addr, input logic [7:0] base,
                                       input int words);
        logic [7:0] off;
        off = addr - base;
        return (addr >= base) && (int'(off) < words);
    endfunction

    always_comb begin
        dec_tgt = TGT_NONE;
        dec_idx = '0;
        if (cpu_we) begin
            if (in_region(cpu_addr, MAP_BASE0, MAP_WORDS)) begin
                dec_tgt = TGT_MAP0;
                dec_idx = 6'(cpu_addr - MAP_BASE0);
            end else if (in_region(cpu_addr, MAP_BASE1, MAP_WORDS)) begin
                dec_tgt = TGT_MAP1;
                dec_idx = 6'(cpu_addr - MAP_BASE1);
            end else if (in_region(cpu_addr, PAL_BASE, PAL_WORDS)) begin
                dec_tgt = TGT_PAL;
                dec_idx = 6'(cpu_addr - PAL_BASE);
            end else if (in_region(cpu_addr, SCR_BASE, SCR_WORDS)) begin
                dec_tgt = TGT_SCROLL;
                dec_idx = 6'(cpu_addr - SCR_BASE);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_tgt <= TGT_NONE;
        end else begin
            wr_tgt <= dec_tgt;
        end
    end

    // Payload follows the strobe
    always_ff @(posedge clk) begin
        wr_idx  <= dec_idx;
        wr_data <= cpu_dout;
    end

    assign wr = '{tgt: wr_tgt, idx: wr_idx, data: wr_data};

    // Scroll words 0..3: L0 hscr, L0 vscr, L1 hscr, L1 vscr
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scroll0 <= '0;
            scroll1 <= '0;
        end else if (dec_tgt == TGT_SCROLL) begin
            case (dec_idx[1:0])
                2'd0: scroll0.hscr <= cpu_dout[5:0];
                2'd1: scroll0.vscr <= cpu_dout[5:0];
                2'd2: scroll1.hscr <= cpu_dout[5:0];
                default: scroll1.vscr <= cpu_dout[5:0];
            endcase
        end
    end

endmodule

/* source/vid_pkg.sv */
// Shared types and constants for the tile video subsystem
// Reduced raster: 80 pixels by 48 lines, of which 64 by 40 are visible
// The write address map assumes an 8-bit word-addressed bus
// Map, palette and scroll regions must not overlap
package vid_pkg;

    // Raster geometry in pixels and lines
    localparam int H_TOTAL  = 80;
    localparam int H_VIS    = 64;
    localparam int V_TOTAL  = 48;
    localparam int V_VIS    = 40;

    // Sync pulses, both limits inclusive
    localparam int HS_START = 68;
    localparam int HS_END   = 71;
    localparam int VS_START = 42;
    localparam int VS_END   = 43;

    // Write regions
    localparam logic [7:0] MAP_BASE0 = 8'h00;
    localparam logic [7:0] MAP_BASE1 = 8'h40;
    localparam logic [7:0] PAL_BASE  = 8'h80;
    localparam logic [7:0] SCR_BASE  = 8'hA0;

    localparam int MAP_WORDS = 64;
    localparam int PAL_WORDS = 32;
    localparam int SCR_WORDS = 4;

    typedef enum logic [2:0] {
        TGT_NONE,
        TGT_MAP0,
        TGT_MAP1,
        TGT_PAL,
        TGT_SCROLL
    } vid_target_e;

    // One decoded bus write, valid for a single clk
    typedef struct packed {
        vid_target_e tgt;
        logic [5:0]  idx;
        logic [15:0] data;
    } vid_wr_t;

    // Raster position
    typedef struct packed {
        logic [6:0] h;
        logic [5:0] v;
        logic       vis;
    } vid_pos_t;

    typedef struct packed {
        logic [5:0] hscr;
        logic [5:0] vscr;
    } vid_scroll_t;

endpackage

/* source/vid_timer.sv */
// Raster counters for the reduced 80x48 frame
// Counters only move on pxl_cen, pos changes on that same clk
// lhbl and lvbl are high inside the visible area
// Sync and blanking are decoded from the counters, no extra latency
`timescale 1ns/1ns

module vid_timer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pxl_cen,
    output vid_pkg::vid_pos_t pos,
    output logic              hs,
    output logic              vs,
    output logic              lhbl,
    output logic              lvbl
);
    import vid_pkg::*;

    logic [6:0] hcnt;
    logic [5:0] vcnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (pxl_cen) begin
            if (hcnt == 7'(H_TOTAL - 1)) begin
                hcnt <= '0;
                // New line
                if (vcnt == 6'(V_TOTAL - 1)) begin
                    vcnt <= '0;
                end else begin
                    vcnt <= vcnt + 6'd1;
                end
            end else begin
                hcnt <= hcnt + 7'd1;
            end
        end
    end

    // Visible window starts at 0,0
    assign lhbl = hcnt < 7'(H_VIS);
    assign lvbl = vcnt < 6'(V_VIS);

    assign hs = (hcnt >= 7'(HS_START)) && (hcnt <= 7'(HS_END));
    assign vs = (vcnt >= 6'(VS_START)) && (vcnt <= 6'(VS_END));

    assign pos = '{h: hcnt, v: vcnt, vis: lhbl & lvbl};

endmodule

/* source/vid_top.sv */
// Tile video subsystem top level
// Two scrolling tile layers over a 32-colour palette, no sprites
// Graphics ROM ports have a fixed one-clk read latency, no handshake
// rgb and the delayed blanking flags belong to the position that
// hdump and vdump showed two pxl_cen ticks earlier
`timescale 1ns/1ns

module vid_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        pxl_cen,
    input  logic        cpu_we,
    input  logic [7:0]  cpu_addr,
    input  logic [15:0] cpu_dout,
    output logic [10:0] gfx0_addr,
    input  logic [31:0] gfx0_data,
    output logic [10:0] gfx1_addr,
    input  logic [31:0] gfx1_data,
    output logic [6:0]  hdump,
    output logic [5:0]  vdump,
    output logic        hs,
    output logic        vs,
    output logic        lhbl_dly,
    output logic        lvbl_dly,
    output logic [4:0]  red,
    output logic [4:0]  green,
    output logic [4:0]  blue
);
    import vid_pkg::*;

    vid_pos_t    pos;
    vid_wr_t     wr;
    vid_scroll_t scroll0;
    vid_scroll_t scroll1;
    logic        lhbl;
    logic        lvbl;
    logic [3:0]  pxl0;
    logic [3:0]  pxl1;

    assign hdump = pos.h;
    assign vdump = pos.v;

    vid_timer u_timer (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .pos      ( pos      ),
        .hs       ( hs       ),
        .vs       ( vs       ),
        .lhbl     ( lhbl     ),
        .lvbl     ( lvbl     )
    );

    vid_mmr u_mmr (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cpu_we   ( cpu_we   ),
        .cpu_addr ( cpu_addr ),
        .cpu_dout ( cpu_dout ),
        .wr       ( wr       ),
        .scroll0  ( scroll0  ),
        .scroll1  ( scroll1  )
    );

    // Front layer
    vid_layer #(.MAP_TGT(TGT_MAP0)) u_layer0 (
        .clk      ( clk       ),
        .rst_n    ( rst_n     ),
        .pxl_cen  ( pxl_cen   ),
        .pos      ( pos       ),
        .scroll   ( scroll0   ),
        .wr       ( wr        ),
        .gfx_addr ( gfx0_addr ),
        .gfx_data ( gfx0_data ),
        .pxl      ( pxl0      )
    );

    // Back layer
    vid_layer #(.MAP_TGT(TGT_MAP1)) u_layer1 (
        .clk      ( clk       ),
        .rst_n    ( rst_n     ),
        .pxl_cen  ( pxl_cen   ),
        .pos      ( pos       ),
        .scroll   ( scroll1   ),
        .wr       ( wr        ),
        .gfx_addr ( gfx1_addr ),
        .gfx_data ( gfx1_data ),
        .pxl      ( pxl1      )
    );

    vid_colmix u_colmix (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .wr       ( wr       ),
        .pxl0     ( pxl0     ),
        .pxl1     ( pxl1     ),
        .lhbl     ( lhbl     ),
        .lvbl     ( lvbl     ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     ),
        .lhbl_dly ( lhbl_dly ),
        .lvbl_dly ( lvbl_dly )
    );

endmodule

/* tb.f */
source/vid_pkg.sv
source/vid_timer.sv
source/vid_mmr.sv
source/vid_layer.sv
source/vid_colmix.sv
source/vid_top.sv
tests/tb_vid.sv

/* tests/tb_vid.sv */
// Testbench for the tile video subsystem
// Graphics ROMs are modelled here with a one-clk read latency
// Map, palette and scroll writes only happen in vertical blank,
// so the shadow copies match the DUT for every checked pixel
// Output pixels are compared two pxl_cen ticks after their position
`timescale 1ns/1ns

module tb_vid;
    import vid_pkg::*;

    localparam int FRAME_CLK = H_TOTAL * V_TOTAL * 4;
    // Five frames of stimulus plus ten lines of margin
    localparam int TIMEOUT   = 5 * FRAME_CLK + 3200;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        pxl_cen = 1'b0;
    logic        cpu_we;
    logic [7:0]  cpu_addr;
    logic [15:0] cpu_dout;
    logic [10:0] gfx0_addr;
    logic [10:0] gfx1_addr;
    logic [31:0] gfx0_data = '0;
    logic [31:0] gfx1_data = '0;
    logic [6:0]  hdump;
    logic [5:0]  vdump;
    logic        hs;
    logic        vs;
    logic        lhbl_dly;
    logic        lvbl_dly;
    logic [4:0]  red;
    logic [4:0]  green;
    logic [4:0]  blue;

    logic [31:0] rom0 [2048];
    logic [31:0] rom1 [2048];
    logic [10:0] rom0_addr = '0;
    logic [10:0] rom1_addr = '0;
    logic [7:0]  map0_sh [64];
    logic [7:0]  map1_sh [64];
    logic [14:0] pal_sh [32];
    logic [5:0]  scr_sh [4];
    logic [1:0]  cen_cnt = '0;
    logic        check_en = 1'b0;
    integer      seed;
    int          cycles = 0;
    int          errors = 0;
    int          checks = 0;
    int          h_d1 = 0;
    int          h_d2 = 0;
    int          v_d1 = 0;
    int          v_d2 = 0;

    vid_top u_vid_top (
        .clk      ( clk       ),
        .rst_n    ( rst_n     ),
        .pxl_cen  ( pxl_cen   ),
        .cpu_we   ( cpu_we    ),
        .cpu_addr ( cpu_addr  ),
        .cpu_dout ( cpu_dout  ),
        .gfx0_addr( gfx0_addr ),
        .gfx0_data( gfx0_data ),
        .gfx1_addr( gfx1_addr ),
        .gfx1_data( gfx1_data ),
        .hdump    ( hdump     ),
        .vdump    ( vdump     ),
        .hs       ( hs        ),
        .vs       ( vs        ),
        .lhbl_dly ( lhbl_dly  ),
        .lvbl_dly ( lvbl_dly  ),
        .red      ( red       ),
        .green    ( green     ),
        .blue     ( blue      )
    );

    always #2 clk = ~clk;

    // Pixel clock enable high one clk in four
    always @(posedge clk) begin
        #1;
        cen_cnt = cen_cnt + 2'd1;
        pxl_cen = (cen_cnt == 2'd0);
    end

    // ROM address taken mid-cycle and data shown just after the next edge
    always @(negedge clk) begin
        rom0_addr <= gfx0_addr;
        rom1_addr <= gfx1_addr;
    end

    always @(posedge clk) begin
        #1;
        gfx0_data = rom0[rom0_addr];
        gfx1_data = rom1[rom1_addr];
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout, test did not finish");
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Plane pixel of one layer where 0 means transparent
    function automatic logic [3:0] layer_pixel(input logic lyr, input int h, input int v);
        int          x;
        int          y;
        int          code;
        logic [31:0] row;
        x = (h + int'(scr_sh[lyr ? 2'd2 : 2'd0])) % 64;
        y = (v + int'(scr_sh[lyr ? 2'd3 : 2'd1])) % 64;
        if (lyr) begin
            code = int'(map1_sh[6'((y / 8) * 8 + x / 8)]);
            row  = rom1[11'(code * 8 + y % 8)];
        end else begin
            code = int'(map0_sh[6'((y / 8) * 8 + x / 8)]);
            row  = rom0[11'(code * 8 + y % 8)];
        end
        return 4'(row >> (4 * (x % 8)));
    endfunction

    function automatic logic [14:0] ref_rgb(input int h, input int v);
        logic [3:0] p0;
        logic [3:0] p1;
        if (h >= H_VIS || v >= V_VIS) begin
            return 15'd0;
        end
        p0 = layer_pixel(1'b0, h, v);
        p1 = layer_pixel(1'b1, h, v);
        // Layer 0 uses the upper half of the palette
        if (p0 != 4'd0) begin
            return pal_sh[5'(16 + int'(p0))];
        end
        return pal_sh[5'(p1)];
    endfunction

    task automatic report_mismatch(input string name, input int h, input int v,
                                   input logic [31:0] exp_val, input logic [31:0] act_val);
        errors++;
        $display("Fail %s at h=%0d v=%0d: expected %h, actual %h",
                 name, h, v, exp_val, act_val);
    endtask

    // Sampled mid-cycle while pxl_cen is high so outputs still hold the last tick
    always @(negedge clk) begin : check_outputs
        int          exp_h;
        int          exp_v;
        logic [14:0] exp_rgb;
        logic        exp_hs;
        logic        exp_vs;
        if (rst_n && pxl_cen) begin
            if (check_en) begin
                checks++;
                exp_h = (h_d1 == H_TOTAL - 1) ? 0 : h_d1 + 1;
                exp_v = v_d1;
                if (h_d1 == H_TOTAL - 1) begin
                    exp_v = (v_d1 == V_TOTAL - 1) ? 0 : v_d1 + 1;
                end
                if (int'(hdump) != exp_h) begin
                    report_mismatch("hdump", h_d1, v_d1, 32'(exp_h), 32'(hdump));
                end
                if (int'(vdump) != exp_v) begin
                    report_mismatch("vdump", h_d1, v_d1, 32'(exp_v), 32'(vdump));
                end
                exp_hs = (exp_h >= HS_START) && (exp_h <= HS_END);
                exp_vs = (exp_v >= VS_START) && (exp_v <= VS_END);
                if (hs !== exp_hs) begin
                    report_mismatch("hs", exp_h, exp_v, 32'(exp_hs), 32'(hs));
                end
                if (vs !== exp_vs) begin
                    report_mismatch("vs", exp_h, exp_v, 32'(exp_vs), 32'(vs));
                end
                // Pixel output belongs to the position two ticks back
                exp_rgb = ref_rgb(h_d2, v_d2);
                if (red !== exp_rgb[14:10]) begin
                    report_mismatch("red", h_d2, v_d2, 32'(exp_rgb[14:10]), 32'(red));
                end
                if (green !== exp_rgb[9:5]) begin
                    report_mismatch("green", h_d2, v_d2, 32'(exp_rgb[9:5]), 32'(green));
                end
                if (blue !== exp_rgb[4:0]) begin
                    report_mismatch("blue", h_d2, v_d2, 32'(exp_rgb[4:0]), 32'(blue));
                end
                if (lhbl_dly !== (h_d2 < H_VIS)) begin
                    report_mismatch("lhbl_dly", h_d2, v_d2, 32'(h_d2 < H_VIS), 32'(lhbl_dly));
                end
                if (lvbl_dly !== (v_d2 < V_VIS)) begin
                    report_mismatch("lvbl_dly", h_d2, v_d2, 32'(v_d2 < V_VIS), 32'(lvbl_dly));
                end
            end
            h_d2 = h_d1;
            v_d2 = v_d1;
            h_d1 = int'(hdump);
            v_d1 = int'(vdump);
        end
    end

    // Called 1 ns after a rising edge and returns at the same phase
    task automatic bus_write(input logic [7:0] addr, input logic [15:0] data);
        cpu_we   = 1'b1;
        cpu_addr = addr;
        cpu_dout = data;
        @(posedge clk);
        #1;
        cpu_we   = 1'b0;
    endtask

    task automatic write_map(input logic lyr, input logic [5:0] idx, input logic [15:0] data);
        if (lyr) begin
            bus_write(MAP_BASE1 + {2'b00, idx}, data);
            map1_sh[idx] = data[7:0];
        end else begin
            bus_write(MAP_BASE0 + {2'b00, idx}, data);
            map0_sh[idx] = data[7:0];
        end
    endtask

    task automatic write_pal(input logic [4:0] idx, input logic [15:0] data);
        bus_write(PAL_BASE + {3'b000, idx}, data);
        pal_sh[idx] = data[14:0];
    endtask

    task automatic write_scroll(input logic [1:0] word, input logic [15:0] data);
        bus_write(SCR_BASE + {6'd0, word}, data);
        scr_sh[word] = data[5:0];
    endtask

    // Waits for the start of a frame and then early vertical blank
    task automatic wait_vblank();
        @(posedge clk);
        #1;
        while (vdump != 6'd0) begin
            @(posedge clk);
            #1;
        end
        while (vdump != 6'(V_VIS + 1)) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        cpu_we   = 1'b0;
        cpu_addr = 8'h00;
        cpu_dout = 16'h0000;
        seed     = 32'h5950_2d40;
        for (int i = 0; i < 2048; i++) begin
            rom0[11'(i)] = $random(seed);
            rom1[11'(i)] = $random(seed);
        end
        // Tile code 0 of layer 0 is fully transparent
        for (int i = 0; i < 8; i++) begin
            rom0[11'(i)] = 32'd0;
        end

        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Random maps and palette with zero scroll
        wait_vblank();
        for (int i = 0; i < 64; i++) begin
            write_map(1'b0, 6'(i), 16'($random(seed)));
            write_map(1'b1, 6'(i), 16'($random(seed)));
        end
        for (int i = 0; i < 32; i++) begin
            write_pal(5'(i), 16'($random(seed)));
        end
        for (int i = 0; i < 4; i++) begin
            write_scroll(2'(i), 16'h0000);
        end
        check_en = 1'b1;

        // Layer 1 shows everywhere
        wait_vblank();
        for (int i = 0; i < 64; i++) begin
            write_map(1'b0, 6'(i), 16'hAB00);
        end

        wait_vblank();
        for (int i = 0; i < 64; i++) begin
            write_map(1'b0, 6'(i), 16'($random(seed)));
        end
        for (int i = 0; i < 4; i++) begin
            write_scroll(2'(i), 16'($random(seed)));
        end

        // Partial rewrite plus writes that hit no region
        wait_vblank();
        for (int i = 0; i < 32; i += 3) begin
            write_pal(5'(i), 16'($random(seed)));
        end
        for (int i = 0; i < 64; i += 5) begin
            write_map(1'b1, 6'(i), 16'($random(seed)));
        end
        bus_write(8'hA4, 16'hFFFF);
        bus_write(8'hC0, 16'h1234);
        bus_write(8'hFF, 16'($random(seed)));

        wait_vblank();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
